// File: runtime_table_loader_stim.txt
# name  start_addr(hex)  bytes  rvalid_gap  expected_bursts
# rvalid_gap is the idle cycles the memory model leaves after each read beat
one_word     00000100     8  0   1
part_word    00000208     5  1   1
one_burst    00000400   128  0   1
burst_plus   00000410   136  2   2
odd_size     00000837  1001  0   8
gap_tail     0000f000   264  5   3
sixteen      00001000  2048  0  16
slow_tail    00003080  1500  3  12
over_tables  00004000  4096  0  32
tables       00006000  1280  1  10

// File: runtime_table_loader.f
+incdir+.
axi_rd_pkg.sv
table_pkg.sv
transfer_counter.sv
axi_read_issuer.sv
table_loader.sv
loop_sequencer.sv
column_delay_pipe.sv
runtime_table_loader.sv
tb_runtime_table_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the log says so
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f runtime_table_loader.f \
  --top-module tb_runtime_table_loader \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Verification passed" sim.log; then
  exit 0
fi
exit 1

// File: tb_runtime_table_loader.sv
`timescale 1ns/1ns
`include "rtl_loader_params.svh"

module tb_runtime_table_loader;
  import axi_rd_pkg::*;
  import table_pkg::*;

  // history slots before the start edge, and cycles watched after the last entry
  localparam int OFF  = 8;
  localparam int HIST = 128;
  localparam int TAIL = (`NUM_COL - 1) * `PIPE_LATENCY + 2;
  localparam int SPAN = 8 * `MAX_BURST_BEATS;

  logic                    aclk;
  logic                    areset;
  logic                    ctrl_start;
  logic                    ctrl_done;
  axi_addr_t               ctrl_addr_offset;
  logic [`XFER_SIZE_W-1:0] ctrl_xfer_size_in_bytes;
  logic                    arvalid;
  logic                    arready;
  axi_addr_t               araddr;
  arlen_t                  arlen;
  logic                    rvalid;
  logic                    rready;
  axi_data_t               rdata;
  logic                    rlast;
  logic                    start_stream_in;
  logic                    ready_stream_in;
  cfg_ctrl_t [`NUM_COL-1:0] rd_data_ctrl;
  cfg_imm_t  [`NUM_COL-1:0] rd_data_imm;
  itr_t      [`NUM_COL-1:0] itr;

  // byte memory behind the read port
  logic [7:0] mem [0:65535];
  int         seed = 94;
  int         errors = 0;
  int         checks = 0;
  bit         aborted = 1'b0;

  // shared between the main flow and the memory model
  string      test_name = "";
  axi_addr_t  exp_base = '0;
  int         exp_tl = 0;
  int         exp_nb = 0;
  int         gap = 0;
  int         issued = 0;
  int         completed = 0;
  int         done_cnt = 0;
  axi_addr_t  q_addr [$];
  arlen_t     q_len [$];

  // state entries for the stream run, all 32 pointers get touched
  int ent_ptr [5] = '{0, 5, 6, 16, 30};
  int ent_rep [5] = '{5, 0, 10, 16, 3};
  bit ent_last [5] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

  runtime_table_loader DUT (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_done               (ctrl_done),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .m_axi_arvalid           (arvalid),
    .m_axi_arready           (arready),
    .m_axi_araddr            (araddr),
    .m_axi_arlen             (arlen),
    .m_axi_rvalid            (rvalid),
    .m_axi_rready            (rready),
    .m_axi_rdata             (rdata),
    .m_axi_rlast             (rlast),
    .start_stream_in         (start_stream_in),
    .ready_stream_in         (ready_stream_in),
    .rd_data_ctrl            (rd_data_ctrl),
    .rd_data_imm             (rd_data_imm),
    .itr                     (itr)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  //////////////////////////////
  // memory helpers
  //////////////////////////////

  // little endian, byte 0 of a word sits at its lowest address
  function automatic axi_data_t read_word(axi_addr_t a);
    axi_data_t   w;
    logic [15:0] idx;
    for (int b = 0; b < 8; b++) begin
      idx = a[15:0] + 16'(b);
      w[8*b +: 8] = mem[idx];
    end
    return w;
  endfunction

  function automatic void write_word(axi_addr_t a, axi_data_t w);
    logic [15:0] idx;
    for (int b = 0; b < 8; b++) begin
      idx = a[15:0] + 16'(b);
      mem[idx] = w[8*b +: 8];
    end
  endfunction

  // config table c follows the state table and the tables of lower columns
  function automatic axi_addr_t cfg_addr(int c, tbl_addr_t p);
    return exp_base + axi_addr_t'(8 * (`TABLE_DEPTH * (c + 1) + int'(p)));
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_addr(string name, axi_addr_t exp, axi_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_len(string name, arlen_t exp, arlen_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_ctrl(string name, cfg_ctrl_t exp, cfg_ctrl_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_imm(string name, cfg_imm_t exp, cfg_imm_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_itr(string name, itr_t exp, itr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////
  // axi memory model
  //////////////////////////////

  // arready toggles every cycle, R bursts come back in request order
  initial begin : axi_model
    bit        rst;
    bit        ar_hs;
    bit        r_hs;
    bit        r_end;
    axi_addr_t ar_addr_s;
    arlen_t    ar_len_s;
    int        beat;
    int        gap_cnt;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rlast   = 1'b0;
    beat    = 0;
    gap_cnt = 0;
    forever begin
      // sample mid cycle where everything has settled
      @(negedge aclk);
      rst       = areset;
      ar_hs     = arvalid && arready;
      ar_addr_s = araddr;
      ar_len_s  = arlen;
      r_hs      = rvalid;
      r_end     = rvalid && rlast;
      if (ctrl_done && !areset) begin
        done_cnt++;
        if (completed != exp_nb) begin
          errors++;
          $display("ctrl_done came before the final read burst completed in %s", test_name);
        end
      end
      @(posedge aclk);
      #10;
      if (rst) begin
        q_addr.delete();
        q_len.delete();
        issued    = 0;
        completed = 0;
        done_cnt  = 0;
        beat      = 0;
        gap_cnt   = 0;
      end else begin
        if (ar_hs) begin
          if (issued >= exp_nb) begin
            errors++;
            $display("read request beyond the expected burst count in %s", test_name);
          end else begin
            // burst n starts n spans above the aligned base
            check_addr({test_name, " araddr"}, exp_base + axi_addr_t'(issued * SPAN),
                       ar_addr_s);
            check_len({test_name, " arlen"}, (issued == exp_nb - 1)
                      ? arlen_t'(exp_tl % `MAX_BURST_BEATS)
                      : arlen_t'(`MAX_BURST_BEATS - 1), ar_len_s);
          end
          q_addr.push_back(ar_addr_s);
          q_len.push_back(ar_len_s);
          issued++;
        end
        // rready is tied high, so every rvalid cycle is a beat
        if (r_hs) begin
          beat++;
          gap_cnt = gap;
        end
        if (r_end) begin
          void'(q_addr.pop_front());
          void'(q_len.pop_front());
          beat = 0;
          completed++;
        end
        if (issued - completed > `MAX_OUTSTANDING) begin
          errors++;
          $display("%0d bursts outstanding in %s, above the limit of %0d",
                   issued - completed, test_name, `MAX_OUTSTANDING);
        end
      end
      arready = !arready;
      // next beat, or an idle gap cycle
      if (gap_cnt > 0) begin
        rvalid = 1'b0;
        rlast  = 1'b0;
        gap_cnt--;
      end else if (q_addr.size() > 0) begin
        rvalid = 1'b1;
        rdata  = read_word(q_addr[0] + axi_addr_t'(8 * beat));
        rlast  = (beat == int'(q_len[0]));
      end else begin
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic step();
    @(posedge aclk);
    #10;
  endtask

  task automatic apply_reset();
    areset = 1'b1;
    repeat (5) step();
    areset = 1'b0;
  endtask

  // state words sit at the start of the load
  task automatic load_entries();
    for (int i = 0; i < 5; i++) begin
      write_word(exp_base + axi_addr_t'(8 * i),
                 axi_data_t'({ent_last[i], 8'(ent_rep[i]), 5'(ent_ptr[i])}));
    end
  endtask

  task automatic run_stream(string name);
    tbl_addr_t ptr_h [HIST];
    itr_t      itr_h [HIST];
    bit        ev    [HIST];
    axi_data_t w;
    int        b;
    int        r;
    int        i;
    int        d;
    int        end_j;
    int        wait_cnt;
    // expected column 0 trace, slot j+OFF holds the value after edge T+j
    for (int j = 0; j < HIST; j++) begin
      ev[j]    = 1'b0;
      ptr_h[j] = '0;
      itr_h[j] = '0;
    end
    b = 0;
    i = 0;
    end_j = 0;
    do begin
      // a repeat of 0 still runs once
      r = (ent_rep[i] == 0) ? 1 : ent_rep[i];
      for (int k = 0; k < r; k++) begin
        ev[b + 3 + k + OFF]    = 1'b1;
        ptr_h[b + 3 + k + OFF] = tbl_addr_t'((ent_ptr[i] + k) % `TABLE_DEPTH);
        itr_h[b + 3 + k + OFF] = itr_t'(k);
      end
      // last run edge acts as the start edge of the next fetch
      end_j = b + 2 + r;
      b = end_j;
      i++;
    end while (!ent_last[i - 1]);
    // outputs hold between run edges
    for (int j = 1; j < HIST; j++) begin
      if (!ev[j]) begin
        ptr_h[j] = ptr_h[j - 1];
        itr_h[j] = itr_h[j - 1];
      end
    end
    wait_cnt = 0;
    while (!ready_stream_in && wait_cnt < 100) begin
      step();
      wait_cnt++;
    end
    if (!ready_stream_in) begin
      errors++;
      aborted = 1'b1;
      $display("timeout waiting for ready_stream_in before the stream in %s", name);
    end else begin
      start_stream_in = 1'b1;
      for (int j = 0; j <= end_j + TAIL; j++) begin
        step();
        start_stream_in = 1'b0;
        for (int c = 0; c < `NUM_COL; c++) begin
          // column c lags column 0, and config data lags its pointer by one
          d = c * `PIPE_LATENCY;
          w = read_word(cfg_addr(c, ptr_h[j - d - 1 + OFF]));
          check_itr($sformatf("%s col%0d itr cycle %0d", name, c, j),
                    itr_h[j - d + OFF], itr[c]);
          check_ctrl($sformatf("%s col%0d ctrl cycle %0d", name, c, j),
                     cfg_ctrl_t'(w[15:0]), rd_data_ctrl[c]);
          check_imm($sformatf("%s col%0d imm cycle %0d", name, c, j),
                    cfg_imm_t'(w[63:32]), rd_data_imm[c]);
        end
        check_bit($sformatf("%s ready cycle %0d", name, j), j >= end_j, ready_stream_in);
      end
    end
  endtask

  task automatic run_load(string name, axi_addr_t addr, int bytes, int gap_v, int bursts);
    int words;
    int wait_cnt;
    apply_reset();
    test_name = name;
    gap       = gap_v;
    // whole words, then full bursts plus one carrying the rest
    words     = (bytes + 7) / 8;
    exp_tl    = words - 1;
    exp_nb    = exp_tl / `MAX_BURST_BEATS + 1;
    exp_base  = addr & ~axi_addr_t'(SPAN - 1);
    if (bytes == (`NUM_COL + 1) * `TABLE_DEPTH * 8) begin
      load_entries();
    end
    ctrl_addr_offset        = addr;
    ctrl_xfer_size_in_bytes = bytes[`XFER_SIZE_W-1:0];
    ctrl_start              = 1'b1;
    step();
    ctrl_start = 1'b0;
    wait_cnt = 0;
    while (done_cnt == 0 && wait_cnt < 20000) begin
      step();
      wait_cnt++;
    end
    if (done_cnt == 0) begin
      errors++;
      aborted = 1'b1;
      $display("timeout waiting for ctrl_done in %s", name);
    end else begin
      // room for a stray second pulse to show up
      repeat (4) step();
      check_count({name, " bursts issued"}, exp_nb, issued);
      check_count({name, " bursts from stim"}, bursts, completed);
      check_count({name, " done pulses"}, 1, done_cnt);
      check_bit({name, " rready"}, 1'b1, rready);
      if (bytes == (`NUM_COL + 1) * `TABLE_DEPTH * 8) begin
        run_stream(name);
      end
    end
  endtask

  initial begin : main_flow
    int        fd;
    int        n;
    string     line;
    string     name;
    axi_addr_t addr_v;
    int        bytes;
    int        gap_v;
    int        bursts;
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    start_stream_in         = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 8'($random(seed));
    end
    fd = $fopen("runtime_table_loader_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      aborted = 1'b1;
      $display("could not open runtime_table_loader_stim.txt");
    end
    while (!aborted && !$feof(fd)) begin
      n = $fgets(line, fd);
      // lines starting with # describe the columns
      if (n > 0 && line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%s %h %d %d %d", name, addr_v, bytes, gap_v, bursts);
        if (n == 5) begin
          run_load(name, addr_v, bytes, gap_v, bursts);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: runtime_table_loader.sv
`timescale 1ns/1ns
`include "rtl_loader_params.svh"

module runtime_table_loader (
  input  logic                                aclk,
  input  logic                                areset,
  input  logic                                ctrl_start,
  output logic                                ctrl_done,
  input  axi_rd_pkg::axi_addr_t               ctrl_addr_offset,
  input  logic [`XFER_SIZE_W-1:0]             ctrl_xfer_size_in_bytes,
  output logic                                m_axi_arvalid,
  input  logic                                m_axi_arready,
  output axi_rd_pkg::axi_addr_t               m_axi_araddr,
  output axi_rd_pkg::arlen_t                  m_axi_arlen,
  input  logic                                m_axi_rvalid,
  output logic                                m_axi_rready,
  input  axi_rd_pkg::axi_data_t               m_axi_rdata,
  input  logic                                m_axi_rlast,
  input  logic                                start_stream_in,
  output logic                                ready_stream_in,
  output table_pkg::cfg_ctrl_t [`NUM_COL-1:0] rd_data_ctrl,
  output table_pkg::cfg_imm_t  [`NUM_COL-1:0] rd_data_imm,
  output table_pkg::itr_t      [`NUM_COL-1:0] itr
);
  import table_pkg::*;

  tbl_addr_t [`NUM_COL-1:0] col_ptr;
  tbl_addr_t                state_rd_addr;
  state_entry_t             state_entry;

  // no data buffering here, every beat goes straight into a table
  assign m_axi_rready = 1'b1;

  axi_read_issuer u_issuer (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .arvalid                 (m_axi_arvalid),
    .arready                 (m_axi_arready),
    .araddr                  (m_axi_araddr),
    .arlen                   (m_axi_arlen),
    .rvalid                  (m_axi_rvalid),
    .rlast                   (m_axi_rlast),
    .ctrl_done               (ctrl_done)
  );

  table_loader u_tables (
    .aclk          (aclk),
    .areset        (areset),
    .rvalid        (m_axi_rvalid),
    .rdata         (m_axi_rdata),
    .state_rd_addr (state_rd_addr),
    .state_entry   (state_entry),
    .col_ptr       (col_ptr),
    .rd_data_ctrl  (rd_data_ctrl),
    .rd_data_imm   (rd_data_imm)
  );

  // column 0 is fed directly by the sequencer
  loop_sequencer u_seq (
    .aclk            (aclk),
    .areset          (areset),
    .ctrl_done       (ctrl_done),
    .start_stream_in (start_stream_in),
    .ready_stream_in (ready_stream_in),
    .state_rd_addr   (state_rd_addr),
    .state_entry     (state_entry),
    .ptr             (col_ptr[0]),
    .itr             (itr[0])
  );

  // each later column sees the previous one a few cycles late
  for (genvar c = 0; c < `NUM_COL-1; c++) begin : g_pipe
    column_delay_pipe u_pipe (
      .aclk    (aclk),
      .areset  (areset),
      .ptr_in  (col_ptr[c]),
      .itr_in  (itr[c]),
      .ptr_out (col_ptr[c+1]),
      .itr_out (itr[c+1])
    );
  end

endmodule

// File: column_delay_pipe.sv
`timescale 1ns/1ns
`include "rtl_loader_params.svh"

module column_delay_pipe (
  input  logic                  aclk,
  input  logic                  areset,
  input  table_pkg::tbl_addr_t  ptr_in,
  input  table_pkg::itr_t       itr_in,
  output table_pkg::tbl_addr_t  ptr_out,
  output table_pkg::itr_t       itr_out
);
  import table_pkg::*;

  tbl_addr_t ptr_q [`PIPE_LATENCY];
  itr_t      itr_q [`PIPE_LATENCY];

  // one column hop, pointer and iteration move together
  always_ff @(posedge aclk) begin
    if (areset) begin
      for (int i = 0; i < `PIPE_LATENCY; i++) begin
        ptr_q[i] <= '0;
        itr_q[i] <= '0;
      end
    end else begin
      ptr_q[0] <= ptr_in;
      itr_q[0] <= itr_in;
      for (int i = 1; i < `PIPE_LATENCY; i++) begin
        ptr_q[i] <= ptr_q[i-1];
        itr_q[i] <= itr_q[i-1];
      end
    end
  end

  assign ptr_out = ptr_q[`PIPE_LATENCY-1];
  assign itr_out = itr_q[`PIPE_LATENCY-1];

endmodule

// File: loop_sequencer.sv
`timescale 1ns/1ns
`include "rtl_loader_params.svh"

module loop_sequencer (
  input  logic                     aclk,
  input  logic                     areset,
  input  logic                     ctrl_done,
  input  logic                     start_stream_in,
  output logic                     ready_stream_in,
  output table_pkg::tbl_addr_t     state_rd_addr,
  input  table_pkg::state_entry_t  state_entry,
  output table_pkg::tbl_addr_t     ptr,
  output table_pkg::itr_t          itr
);
  import table_pkg::*;

  seq_state_e   state;
  state_entry_t entry_r;
  itr_t         iter_cnt;
  itr_t         iter_last;

  // repeat of 0 still runs once
  assign iter_last = (entry_r.repeat_cnt == '0) ? '0 : itr_t'(entry_r.repeat_cnt - 1'b1);

  always_ff @(posedge aclk) begin
    if (areset) begin
      state           <= IDLE_WAIT_LOAD;
      ready_stream_in <= 1'b0;
      state_rd_addr   <= '0;
      iter_cnt        <= '0;
      ptr             <= '0;
      itr             <= '0;
    end else if (ctrl_done) begin
      // a finished load always rearms the stream
      state           <= READY;
      ready_stream_in <= 1'b1;
    end else begin
      case (state)
        READY: begin
          if (start_stream_in) begin
            state_rd_addr   <= '0;
            ready_stream_in <= 1'b0;
            state           <= FETCH_ADDR;
          end
        end
        // table read is in flight
        FETCH_ADDR: state <= FETCH_DATA;
        FETCH_DATA: begin
          entry_r  <= state_entry;
          iter_cnt <= '0;
          state    <= RUN;
        end
        RUN: begin
          ptr <= entry_r.cfg_ptr + tbl_addr_t'(iter_cnt);
          itr <= iter_cnt;
          if (iter_cnt != iter_last) begin
            iter_cnt <= iter_cnt + 1'b1;
          end else if (entry_r.last ||
                       state_rd_addr == tbl_addr_t'(`TABLE_DEPTH - 1)) begin
            state           <= READY;
            ready_stream_in <= 1'b1;
          end else begin
            // next entry, fetched straight away
            state_rd_addr <= state_rd_addr + 1'b1;
            state         <= FETCH_ADDR;
          end
        end
        default: state <= IDLE_WAIT_LOAD;
      endcase
    end
  end

  a_ready_in_ready: assert property (@(posedge aclk) disable iff (areset)
    ready_stream_in == (state == READY));

endmodule

// File: table_loader.sv
`timescale 1ns/1ns
`include "rtl_loader_params.svh"

module table_loader (
  input  logic                                   aclk,
  input  logic                                   areset,
  input  logic                                   rvalid,
  input  axi_rd_pkg::axi_data_t                  rdata,
  input  table_pkg::tbl_addr_t                   state_rd_addr,
  output table_pkg::state_entry_t                state_entry,
  input  table_pkg::tbl_addr_t [`NUM_COL-1:0]    col_ptr,
  output table_pkg::cfg_ctrl_t [`NUM_COL-1:0]    rd_data_ctrl,
  output table_pkg::cfg_imm_t  [`NUM_COL-1:0]    rd_data_imm
);
  import table_pkg::*;

  tbl_addr_t    wr_idx;
  table_sel_t   wr_sel;
  state_entry_t state_mem [`TABLE_DEPTH];

  //////////////////////////////
  // write stepping
  //////////////////////////////

  // one flat stream across bursts
  // state table first, then each config table in column order
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_idx <= '0;
      wr_sel <= table_sel_t'(1);
    end else if (rvalid && wr_sel != '0) begin
      wr_idx <= wr_idx + 1'b1;
      // index wraps naturally at the table end, then move on
      if (wr_idx == tbl_addr_t'(`TABLE_DEPTH - 1)) begin
        wr_sel <= wr_sel << 1;
      end
    end
  end

  //////////////////////////////
  // memories
  //////////////////////////////

  always_ff @(posedge aclk) begin
    if (rvalid && wr_sel[0]) begin
      state_mem[wr_idx] <= rdata[$bits(state_entry_t)-1:0];
    end
    state_entry <= state_mem[state_rd_addr];
  end

  for (genvar c = 0; c < `NUM_COL; c++) begin : g_cfg
    cfg_ctrl_t ctrl_mem [`TABLE_DEPTH];
    cfg_imm_t  imm_mem  [`TABLE_DEPTH];
    cfg_ctrl_t ctrl_q;
    cfg_imm_t  imm_q;

    always_ff @(posedge aclk) begin
      if (rvalid && wr_sel[c+1]) begin
        ctrl_mem[wr_idx] <= rdata[$bits(cfg_ctrl_t)-1:0];
        imm_mem[wr_idx]  <= rdata[`AXI_DATA_W-1 -: $bits(cfg_imm_t)];
      end
      // registered read, one cycle behind the column pointer
      ctrl_q <= ctrl_mem[col_ptr[c]];
      imm_q  <= imm_mem[col_ptr[c]];
    end

    assign rd_data_ctrl[c] = ctrl_q;
    assign rd_data_imm[c]  = imm_q;
  end

  // zero once every table is full
  a_sel_onehot: assert property (@(posedge aclk) disable iff (areset)
    $onehot0(wr_sel));

endmodule

// File: axi_read_issuer.sv
`timescale 1ns/1ns
`include "rtl_loader_params.svh"

module axi_read_issuer (
  input  logic                     aclk,
  input  logic                     areset,
  input  logic                     ctrl_start,
  input  axi_rd_pkg::axi_addr_t    ctrl_addr_offset,
  input  logic [`XFER_SIZE_W-1:0]  ctrl_xfer_size_in_bytes,
  output logic                     arvalid,
  input  logic                     arready,
  output axi_rd_pkg::axi_addr_t    araddr,
  output axi_rd_pkg::arlen_t       arlen,
  input  logic                     rvalid,
  input  logic                     rlast,
  output logic                     ctrl_done
);
  import axi_rd_pkg::*;

  localparam axi_addr_t ADDR_MASK = axi_addr_t'(BURST_BYTES - 1);

  logic         start_d1;
  logic         start;
  beat_count_t  total_len_r;
  axi_addr_t    addr_offset_r;
  burst_count_t num_bursts;
  logic         ar_idle;
  logic         ar_final;
  logic         arxfer;
  logic         r_active;
  logic         r_final;
  logic         r_last_beat;
  logic         done_cond;
  logic         stall_ar;
  vacancy_t     vacancy;

  //////////////////////////////
  // request setup
  //////////////////////////////

  // round bytes up to whole words, kept as words minus one
  // base address snaps down to a burst span
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      total_len_r <= (ctrl_xfer_size_in_bytes[LOG_DW_BYTES-1:0] != '0)
        ? ctrl_xfer_size_in_bytes[LOG_DW_BYTES +: BEAT_CNT_W]
        : ctrl_xfer_size_in_bytes[LOG_DW_BYTES +: BEAT_CNT_W] - 1'b1;
      addr_offset_r <= ctrl_addr_offset & ~ADDR_MASK;
    end
  end

  // two stage start delay
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

  // full bursts minus one, the remainder rides in the final burst
  assign num_bursts = total_len_r[LOG_BURST_LEN +: BURST_CNT_W];

  //////////////////////////////
  // address channel
  //////////////////////////////

  assign arxfer = arvalid & arready;
  assign arlen  = ar_final ? arlen_t'(total_len_r[LOG_BURST_LEN-1:0])
                           : arlen_t'(`MAX_BURST_BEATS - 1);

  // raise when work is left and a slot is free, hold until arready
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
      ar_idle <= 1'b1;
    end else begin
      arvalid <= (!ar_idle && !stall_ar && !arvalid) ? 1'b1 :
                 arready ? 1'b0 : arvalid;
      ar_idle <= start ? 1'b0 : (ar_final && arxfer) ? 1'b1 : ar_idle;
    end
  end

  always_ff @(posedge aclk) begin
    if (start) begin
      araddr <= addr_offset_r;
    end else if (arxfer) begin
      araddr <= araddr + axi_addr_t'(BURST_BYTES);
    end
  end

  // address bursts still to issue
  transfer_counter #(.WIDTH($bits(burst_count_t)), .RESET_VALUE('0)) u_ar_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (arxfer & ~ar_final),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (ar_final)
  );

  // free outstanding slots, returned at each rlast
  transfer_counter #(.WIDTH($bits(vacancy_t)),
                     .RESET_VALUE(vacancy_t'(`MAX_OUTSTANDING))) u_vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (r_last_beat),
    .decr       (arxfer),
    .load_value ('0),
    .count      (vacancy),
    .is_zero    (stall_ar)
  );

  //////////////////////////////
  // read channel and done
  //////////////////////////////

  // rready is tied high, so every rvalid beat is taken
  assign r_last_beat = rvalid & rlast;
  assign done_cond   = r_last_beat & r_final & r_active;

  always_ff @(posedge aclk) begin
    if (areset) begin
      r_active  <= 1'b0;
      ctrl_done <= 1'b0;
    end else begin
      r_active  <= start ? 1'b1 : done_cond ? 1'b0 : r_active;
      ctrl_done <= done_cond;
    end
  end

  // read bursts still to complete
  transfer_counter #(.WIDTH($bits(burst_count_t)), .RESET_VALUE('0)) u_r_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (r_last_beat & r_active & ~r_final),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (r_final)
  );

  a_ar_stable: assert property (@(posedge aclk) disable iff (areset)
    (arvalid && !arready) |=> (arvalid && $stable(araddr) && $stable(arlen)));

  // a pending request always owns a slot
  a_ar_slot: assert property (@(posedge aclk) disable iff (areset)
    arvalid |-> (vacancy != '0));

endmodule

// File: transfer_counter.sv
`timescale 1ns/1ns

module transfer_counter #(
  parameter int               WIDTH       = 8,
  parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // load wins, simultaneous incr and decr cancel
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= RESET_VALUE;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  assign is_zero = (count == '0);

  // callers must stop decrementing once the count has drained
  a_no_underflow: assert property (@(posedge aclk) disable iff (areset)
    (decr && !incr && !load) |-> !is_zero);

endmodule

// File: table_pkg.sv
`include "rtl_loader_params.svh"

package table_pkg;

  typedef logic [$clog2(`TABLE_DEPTH)-1:0] tbl_addr_t;

  // one-hot write select
  // bit 0 is the state table, bit c+1 is the config table of column c
  typedef logic [`NUM_COL:0] table_sel_t;

  // state entry sits in the low bits of a bus word, cfg_ptr lowest
  typedef struct packed {
    logic       last;
    logic [7:0] repeat_cnt;
    tbl_addr_t  cfg_ptr;
  } state_entry_t;

  // config word, ctrl in the low half-word and imm in the upper word
  typedef logic [15:0] cfg_ctrl_t;
  typedef logic [31:0] cfg_imm_t;

  typedef logic [15:0] itr_t;

  typedef enum logic [2:0] {
    IDLE_WAIT_LOAD,
    READY,
    FETCH_ADDR,
    FETCH_DATA,
    RUN
  } seq_state_e;

endpackage

// File: axi_rd_pkg.sv
`include "rtl_loader_params.svh"

package axi_rd_pkg;

  // derived sizes of the read side
  localparam int DW_BYTES      = `AXI_DATA_W / 8;
  localparam int LOG_DW_BYTES  = $clog2(DW_BYTES);
  localparam int LOG_BURST_LEN = $clog2(`MAX_BURST_BEATS);
  localparam int BURST_BYTES   = DW_BYTES * `MAX_BURST_BEATS;
  localparam int BEAT_CNT_W    = `XFER_SIZE_W - LOG_DW_BYTES;
  localparam int BURST_CNT_W   = BEAT_CNT_W - LOG_BURST_LEN;
  localparam int VACANCY_W     = $clog2(`MAX_OUTSTANDING + 1);

  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0] axi_data_t;
  // arlen encoding, beats minus one
  typedef logic [7:0]             arlen_t;
  typedef logic [BEAT_CNT_W-1:0]  beat_count_t;
  typedef logic [BURST_CNT_W-1:0] burst_count_t;
  typedef logic [VACANCY_W-1:0]   vacancy_t;

endpackage

// File: rtl_loader_params.svh
`ifndef RTL_LOADER_PARAMS_SVH
`define RTL_LOADER_PARAMS_SVH

//////////////////////////////
// axi read side
//////////////////////////////

// byte address width
`define AXI_ADDR_W 32
// one bus word is 8 bytes
`define AXI_DATA_W 64
// width of the requested byte count
`define XFER_SIZE_W 16
// longest burst we ever issue, in beats
`define MAX_BURST_BEATS 16
// bursts allowed in flight before the ar side stalls
`define MAX_OUTSTANDING 4

//////////////////////////////
// tables and columns
//////////////////////////////

`define TABLE_DEPTH 32
`define NUM_COL 4
// register stages between neighbouring columns
`define PIPE_LATENCY 2

`endif
